// File: design/wrand_consts.svh
`ifndef WRAND_CONSTS_SVH
`define WRAND_CONSTS_SVH

// number of work queues behind the scheduler
`define WRAND_NUM_QUEUES 4

// cumulative weights and the random number share this width
// the arbiter compares them directly, so it stays at 8 bits
`define WRAND_WEIGHT_W 8

// start value of the random generator
// it must be nonzero or the LFSR locks up
`define WRAND_LFSR_SEED 8'hA5

// width of each pending-work counter
`define WRAND_COUNT_W 8

`endif

// File: design/wrand_pkg.sv
`default_nettype none

`include "wrand_consts.svh"

package wrand_pkg;

  // cumulative weight threshold, one per queue
  typedef logic [`WRAND_WEIGHT_W-1:0] weight_t;

  // pending work units in one queue, saturating at all ones
  typedef logic [`WRAND_COUNT_W-1:0] count_t;

  // queue index wide enough for every queue
  typedef logic [$clog2(`WRAND_NUM_QUEUES)-1:0] qid_t;

  // static weight table with queue 0 in the low bits
  // weights are expected to be non-decreasing from queue 0 upward
  typedef struct packed {
    weight_t [`WRAND_NUM_QUEUES-1:0] w;
  } weight_cfg_t;

  // one unit of work arriving for queue qid
  typedef struct packed {
    logic valid;
    qid_t qid;
  } enq_cmd_t;

  // one unit of work leaving queue qid
  // boosted means the random pick beat the strict priority order
  typedef struct packed {
    logic valid;
    qid_t qid;
    logic boosted;
  } deq_grant_t;

endpackage

`default_nettype wire

// File: design/lfsr_random8.sv
`default_nettype none

`include "wrand_consts.svh"

module lfsr_random8
  import wrand_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic update,
  output weight_t   random
);

  // feedback taps for x^8 + x^6 + x^5 + x^4 + 1 in right shifting Galois form
  localparam weight_t TAPS = 8'hB8;

  weight_t lfsr_q;
  weight_t lfsr_next;

  // shift right and fold the outgoing bit back into the tap positions
  // a maximal polynomial walks through all 255 nonzero states
  always_comb begin
    lfsr_next = {1'b0, lfsr_q[`WRAND_WEIGHT_W-1:1]};
    if (lfsr_q[0]) begin
      lfsr_next = lfsr_next ^ TAPS;
    end
  end

  // the state only moves when the arbiter consumed the current value
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lfsr_q <= `WRAND_LFSR_SEED;
    end else if (update) begin
      lfsr_q <= lfsr_next;
    end
  end

  // the arbiter sees the current state directly
  assign random = lfsr_q;

endmodule

`default_nettype wire

// File: design/req_queue_slot.sv
`default_nettype none

module req_queue_slot
  import wrand_pkg::*;
#(
  parameter int QID = 0
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  enq_cmd_t  enq,
  input  wire logic pop,
  output logic      nonempty,
  output logic      drop
);

  count_t count_q;
  logic   match;
  logic   full;
  logic   drop_q;

  // each slot steers the shared enqueue port to itself by index
  assign match = enq.valid && (enq.qid == qid_t'(QID));

  // a saturated counter cannot take another unit
  assign full = (count_q == '1);

  // an arrival and a departure in the same cycle cancel out
  // a refused arrival leaves the count where it is
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (match && !pop) begin
      if (!full) begin
        count_q <= count_q + 1'b1;
      end
    end else if (pop && !match) begin
      count_q <= count_q - 1'b1;
    end
  end

  // flag a lost unit for one cycle after the refused enqueue
  // a pop in the same cycle frees room, so nothing is lost then
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      drop_q <= 1'b0;
    end else begin
      drop_q <= match && full && !pop;
    end
  end

  // the arbiter treats any pending work as a request
  assign nonempty = (count_q != '0);
  assign drop     = drop_q;

endmodule

`default_nettype wire

// File: design/wrand_arb.sv
`default_nettype none

`include "wrand_consts.svh"

module wrand_arb
  import wrand_pkg::*;
(
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic [`WRAND_NUM_QUEUES-1:0] reqs,
  input  weight_cfg_t                       weights,
  input  weight_t                           random,
  input  wire logic                         sched_en,
  input  wire logic [`WRAND_NUM_QUEUES-1:0] drops,
  output logic      [`WRAND_NUM_QUEUES-1:0] pop,
  output logic                              rand_update,
  output deq_grant_t                        grant,
  output logic                              enq_drop
);

  localparam int NQ = `WRAND_NUM_QUEUES;

  weight_t [NQ-1:0] lower;
  logic             weight_v;
  qid_t             weight_qid;
  logic             strict_v;
  qid_t             strict_qid;
  logic             win_v;
  qid_t             win_qid;
  logic             fire;
  deq_grant_t       grant_q;

  // the lower bound of each weight range is the weight of the queue below
  // queue 0 starts its range at zero
  always_comb begin
    lower[0] = '0;
    for (int i = 1; i < NQ; i++) begin
      lower[i] = weights.w[i-1];
    end
  end

  // a queue is a weighted candidate when random falls inside its range
  // scanning upward lets the highest matching index win
  always_comb begin
    weight_v   = 1'b0;
    weight_qid = '0;
    for (int i = 0; i < NQ; i++) begin
      if (reqs[i] && (weights.w[i] != '0) &&
          (random > lower[i]) && (random <= weights.w[i])) begin
        weight_v   = 1'b1;
        weight_qid = qid_t'(i);
      end
    end
  end

  // strict fallback picks the lowest requesting index
  // scanning downward leaves the lowest one in place
  always_comb begin
    strict_v   = 1'b0;
    strict_qid = '0;
    for (int i = NQ - 1; i >= 0; i--) begin
      if (reqs[i]) begin
        strict_v   = 1'b1;
        strict_qid = qid_t'(i);
      end
    end
  end

  // the weighted pick takes precedence whenever one exists
  assign win_v   = weight_v || strict_v;
  assign win_qid = weight_v ? weight_qid : strict_qid;
  assign fire    = sched_en && win_v;

  // one pop pulse to the winning slot in the decision cycle
  always_comb begin
    pop = '0;
    if (fire) begin
      pop[win_qid] = 1'b1;
    end
  end

  // the random number moves on only after a weighted pick used it
  assign rand_update = sched_en && weight_v;

  // grant shows the decision one cycle after the slot was drained
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      grant_q <= '0;
    end else begin
      grant_q.valid   <= fire;
      grant_q.qid     <= win_qid;
      grant_q.boosted <= fire && weight_v && (weight_qid > strict_qid);
    end
  end

  assign grant = grant_q;

  // slot drop flags are already registered, so one OR gives the pulse
  assign enq_drop = |drops;

endmodule

`default_nettype wire

// File: design/wrand_sched.sv
`default_nettype none

`include "wrand_consts.svh"

module wrand_sched
  import wrand_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  enq_cmd_t   enq,
  input  weight_cfg_t weights,
  input  wire logic  sched_en,
  output deq_grant_t grant,
  output logic       enq_drop
);

  localparam int NQ = `WRAND_NUM_QUEUES;

  // per-slot request, pop and drop lines
  logic [NQ-1:0] nonempty;
  logic [NQ-1:0] pop;
  logic [NQ-1:0] drops;

  // random number and its step strobe between arbiter and LFSR
  weight_t random;
  logic    rand_update;

  // identical counters, each one picking its own enqueues by index
  for (genvar g = 0; g < NQ; g++) begin : g_slot
    req_queue_slot #(
      .QID (g)
    ) u_slot (
      .clk      (clk),
      .rst_n    (rst_n),
      .enq      (enq),
      .pop      (pop[g]),
      .nonempty (nonempty[g]),
      .drop     (drops[g])
    );
  end

  // decides which queue drains and registers the grant
  wrand_arb u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .reqs        (nonempty),
    .weights     (weights),
    .random      (random),
    .sched_en    (sched_en),
    .drops       (drops),
    .pop         (pop),
    .rand_update (rand_update),
    .grant       (grant),
    .enq_drop    (enq_drop)
  );

  // random source that steps only on weighted picks
  lfsr_random8 u_lfsr (
    .clk    (clk),
    .rst_n  (rst_n),
    .update (rand_update),
    .random (random)
  );

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 5
) (
  input  wire logic restart,
  output logic      clk,
  output logic      rst_n
);

  logic clk_q = 1'b0;
  logic rst_q = 1'b0;
  int   held  = 0;

  always #(PERIOD / 2) clk_q = ~clk_q;

  // counts rising edges seen in reset, restart starts the count over
  always @(posedge clk_q) begin
    if (restart) begin
      held <= 0;
    end else if (held < RST_CYCLES) begin
      held <= held + 1;
    end
  end

  // reset changes on the falling edge like every other DUT input
  always @(negedge clk_q) begin
    rst_q <= (held >= RST_CYCLES);
  end

  assign clk   = clk_q;
  assign rst_n = rst_q;

endmodule

`default_nettype wire

// File: testbench/tb_wrand_sched.sv
`default_nettype none

`include "wrand_consts.svh"

module tb_wrand_sched
  import wrand_pkg::*;
();

  localparam int NQ        = `WRAND_NUM_QUEUES;
  localparam int MAX_TESTS = 16;

  logic        clk;
  logic        rst_n;
  logic        restart;
  logic        sched_en;
  logic        enq_drop;
  enq_cmd_t    enq;
  weight_cfg_t weights;
  deq_grant_t  grant;

  // case columns: stress, w0..w3, e0..e3, grants, x0..x3, drops
  logic [8*32-1:0] case_name [MAX_TESTS];
  int              case_val [MAX_TESTS][15];
  int              n_tests;
  int              limit;
  int              cycles = 0;

  // occupancy model and per-test counters
  logic [8*32-1:0] cur_name;
  int              cur_w [NQ];
  int              model [NQ];
  int              granted [NQ];
  int              granted_total;
  int              drops_seen;
  int              errors = 0;
  int              test_errors;
  int              tests_failed = 0;
  logic [31:0]     rng = 32'h37312cb9;

  tb_clk_gen u_clk_gen (
    .restart (restart),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  wrand_sched u_wrand_sched (
    .clk      (clk),
    .rst_n    (rst_n),
    .enq      (enq),
    .weights  (weights),
    .sched_en (sched_en),
    .grant    (grant),
    .enq_drop (enq_drop)
  );

  // the run stops once it has used every cycle the case table allows
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("ERROR: run stopped after %0d cycles without finishing the tests", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // galois LFSR with taps 32,22,2,1, one step per bit handed out
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      rng = rng[0] ? ((rng >> 1) ^ 32'h80200003) : (rng >> 1);
      v = (v << 1) | int'(rng[0]);
    end
    return v;
  endfunction

  // lowest queue that still holds work in the model, -1 when all are empty
  function automatic int lowest();
    int r;
    r = -1;
    for (int i = NQ - 1; i >= 0; i--) begin
      if (model[i] > 0) begin
        r = i;
      end
    end
    return r;
  endfunction

  task automatic check(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("MISMATCH %0s %0s: expected %0d, actual %0d", cur_name, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  // lines that do not give all sixteen fields are comments
  task automatic read_cases();
    int              fd;
    int              n;
    logic [8*200-1:0] line;
    logic [8*32-1:0] nm;
    int              f [15];
    n_tests = 0;
    limit   = 0;
    fd = $fopen("testbench/wrand_sched_cases.txt", "r");
    if (fd == 0) begin
      return;
    end
    while ($fgets(line, fd) != 0 && n_tests < MAX_TESTS) begin
      n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d", nm, f[0], f[1],
                  f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12], f[13],
                  f[14]);
      if (n == 16) begin
        case_name[n_tests] = nm;
        for (int k = 0; k < 15; k++) begin
          case_val[n_tests][k] = f[k];
        end
        limit += 20 + f[5] + f[6] + f[7] + f[8] + f[9];
        n_tests++;
      end
    end
    $fclose(fd);
  endtask

  // pulses restart and waits until the DUT is out of reset
  task automatic do_reset();
    enq      = '0;
    sched_en = 1'b0;
    @(negedge clk);
    restart = 1'b1;
    @(negedge clk);
    restart = 1'b0;
    @(negedge clk);
    while (!rst_n) begin
      @(negedge clk);
    end
  endtask

  // one cycle, the inputs in place now were sampled at the edge just past
  // grant and enq_drop show what that edge decided, the model still holds the state before it
  task automatic step();
    int   low;
    int   q;
    logic exp_drop;
    @(negedge clk);
    low = lowest();
    check("grant valid", int'(sched_en && low >= 0), int'(grant.valid));
    if (grant.valid) begin
      q = int'(grant.qid);
      if (model[q] == 0) begin
        $display("ERROR %0s: queue %0d was granted with no work left in it", cur_name, q);
        errors++;
        test_errors++;
      end else begin
        // boosted means the pick beat the lowest nonempty queue
        check("boosted", int'(q > low), int'(grant.boosted));
        // a queue without weight only wins on strict priority
        if (cur_w[q] == 0) begin
          check("zero-weight grant qid", low, q);
        end
        model[q]--;
        granted[q]++;
        granted_total++;
      end
    end
    // the pop is already applied, so a full queue here means the unit is lost
    exp_drop = 1'b0;
    if (enq.valid) begin
      q = int'(enq.qid);
      if (model[q] == 255) begin
        exp_drop = 1'b1;
      end else begin
        model[q]++;
      end
    end
    check("enq_drop", int'(exp_drop), int'(enq_drop));
    if (enq_drop) begin
      drops_seen++;
    end
  endtask

  task automatic run_test(input int t);
    int remaining [NQ];
    int left;
    int q;
    cur_name      = case_name[t];
    test_errors   = 0;
    granted_total = 0;
    drops_seen    = 0;
    left          = 0;
    for (int i = 0; i < NQ; i++) begin
      cur_w[i]      = case_val[t][1+i];
      weights.w[i]  = weight_t'(cur_w[i]);
      remaining[i]  = case_val[t][5+i];
      left         += remaining[i];
      granted[i]    = 0;
      model[i]      = 0;
    end
    do_reset();
    // idle cycles straight after reset must stay quiet
    repeat (3) step();
    // a stress case schedules while random enqueues arrive, otherwise preload then drain
    while (left > 0 || granted_total < case_val[t][9]) begin
      q = -1;
      if (left > 0 && (case_val[t][0] == 0 || take_bits(2) != 0)) begin
        q = (case_val[t][0] != 0) ? take_bits(2) : 0;
        while (remaining[q] == 0) begin
          q = (q + 1) % NQ;
        end
        remaining[q]--;
        left--;
      end
      enq.valid = (q >= 0);
      enq.qid   = qid_t'(q < 0 ? 0 : q);
      sched_en  = (case_val[t][0] != 0) || (q < 0);
      step();
    end
    // with nothing left no grant may follow, leftover work stays put
    repeat (3) begin
      enq.valid = 1'b0;
      sched_en  = (lowest() < 0);
      step();
    end
    sched_en = 1'b0;
    for (int i = 0; i < NQ; i++) begin
      check($sformatf("grants of queue %0d", i), case_val[t][10+i], granted[i]);
    end
    check("drop pulses", case_val[t][14], drops_seen);
    if (test_errors == 0) begin
      $display("test %0s: passed with %0d grants", cur_name, granted_total);
    end else begin
      $display("test %0s: failed with %0d errors", cur_name, test_errors);
      tests_failed++;
    end
  endtask

  initial begin
    restart  = 1'b0;
    sched_en = 1'b0;
    enq      = '0;
    weights  = '0;
    read_cases();
    if (n_tests == 0) begin
      $display("ERROR: no test cases could be read from testbench/wrand_sched_cases.txt");
      errors++;
    end else begin
      for (int t = 0; t < n_tests; t++) begin
        run_test(t);
      end
    end
    $display("%0d tests run, %0d failed, %0d check errors", n_tests, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: wrand_sched.f
+incdir+design
design/wrand_pkg.sv
design/lfsr_random8.sv
design/req_queue_slot.sv
design/wrand_arb.sv
design/wrand_sched.sv
testbench/tb_clk_gen.sv
testbench/tb_wrand_sched.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 -f wrand_sched.f --top-module tb_wrand_sched -o tb_wrand_sched
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_wrand_sched > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

// File: testbench/wrand_sched_cases.txt
# name stress w0 w1 w2 w3 e0 e1 e2 e3 grants x0 x1 x2 x3 drops
# stress 1 interleaves random enqueues with scheduling, stress 0 preloads and then drains

# nothing queued, the grant and drop outputs stay low
reset_idle 0 63 127 191 255 0 0 0 0 0 0 0 0 0 0

# one loaded queue, every grant names it and none is boosted
single_q0 0 63 127 191 255 10 0 0 0 10 10 0 0 0 0
single_q2 0 63 127 191 255 0 0 7 0 7 0 0 7 0 0
single_q3_noweight 0 85 170 255 0 0 0 0 5 5 0 0 0 5 0

# a full LFSR period of weighted picks gives each queue its range width
exact_shares 0 63 127 191 255 255 255 255 255 255 63 64 64 64 0

# queue 3 has no weight and only drains once queues 0 to 2 are empty
zero_weight_drain 0 85 170 255 0 20 20 20 20 80 20 20 20 20 0
zero_weight_stress 1 85 170 255 0 40 30 30 40 140 40 30 30 40 0

# random arrivals against uneven weights
mixed_stress 1 16 64 128 255 50 50 50 50 200 50 50 50 50 0

# two units beyond a full counter are refused
overflow_q0 0 63 127 191 255 257 0 0 0 255 255 0 0 0 2
